// File: regex_scan_pkg.sv
`default_nettype none

package regex_scan_pkg;

    // a bank line holds four bytes.
    localparam int data_width = 32;
    localparam int strb_width = data_width / 8;
    localparam int line_addr_bits = 2;

    // each bank holds 64 lines, so both banks together cover 512 bytes.
    localparam int bank_lines = 64;
    localparam int acc_addr_width = 6;
    localparam int pmem_addr_width = 9;

    localparam int len_width = 10;

    // state codes of the "ab*c" matcher.
    localparam logic [1:0] st_idle = 2'd0;
    localparam logic [1:0] st_seen_a = 2'd1;
    localparam logic [1:0] st_seen_ab = 2'd2;

    // a byte address seen either as one counter or split into its fields.
    // bit 2 picks the bank, so even line numbers land in bank 1 and odd
    // line numbers in bank 2.
    typedef union packed {
        logic [pmem_addr_width-1:0] flat;
        struct packed {
            logic [acc_addr_width-1:0] line;
            logic bank;
            logic [line_addr_bits-1:0] byte_sel;
        } fields;
    } scan_addr_u;

endpackage

`default_nettype wire

// File: scan_bank_mem.sv
`default_nettype none

module scan_bank_mem
    import regex_scan_pkg::*;
(
    input logic clk,

    input logic wr_en,
    input logic [acc_addr_width-1:0] wr_line,
    input logic [strb_width-1:0] wr_strb,
    input logic [data_width-1:0] wr_data,

    input logic rd_en,
    input logic [acc_addr_width-1:0] rd_line,
    output logic [data_width-1:0] rd_data
);

    logic [data_width-1:0] mem [bank_lines];

    // each byte lane is written only when its strobe bit is set.
    always_ff @(posedge clk) begin
        for (int i = 0; i < strb_width; i++) begin
            if (wr_en && wr_strb[i]) begin
                mem[wr_line][i*8 +: 8] <= wr_data[i*8 +: 8];
            end
        end
    end

    // the read register keeps its last line while rd_en is low.
    always_ff @(posedge clk) begin
        if (rd_en) begin
            rd_data <= mem[rd_line];
        end
    end

endmodule

`default_nettype wire

// File: regex_ab_c_match.sv
`default_nettype none

module regex_ab_c_match
    import regex_scan_pkg::*;
(
    input logic clk,
    input logic rst,

    input logic [7:0] re_byte,
    input logic re_valid,
    input logic re_clear,

    output logic match
);

    logic [1:0] state_reg;
    logic [1:0] state_next;
    logic match_next;

    always_comb begin
        state_next = state_reg;
        match_next = 1'b0;

        if (re_valid) begin
            case (re_byte)
                8'h61: begin
                    // an 'a' always starts a fresh candidate.
                    state_next = st_seen_a;
                end
                8'h62: begin
                    if (state_reg == st_seen_a || state_reg == st_seen_ab) begin
                        state_next = st_seen_ab;
                    end else begin
                        state_next = st_idle;
                    end
                end
                8'h63: begin
                    if (state_reg == st_seen_a || state_reg == st_seen_ab) begin
                        match_next = 1'b1;
                    end
                    state_next = st_idle;
                end
                default: begin
                    state_next = st_idle;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (rst || re_clear) begin
            state_reg <= st_idle;
            match <= 1'b0;
        end else begin
            state_reg <= state_next;
            match <= match_next;
        end
    end

endmodule

`default_nettype wire

// File: regex_scan_ctrl.sv
`default_nettype none

module regex_scan_ctrl
    import regex_scan_pkg::*;
(
    input logic clk,
    input logic rst,

    input logic [pmem_addr_width-1:0] cmd_addr,
    input logic [len_width-1:0] cmd_len,
    input logic cmd_valid,
    input logic cmd_stop,
    output logic cmd_ready,

    output logic status_match,
    output logic status_done,

    output logic rd_en_b1,
    output logic [acc_addr_width-1:0] rd_line_b1,
    input logic [data_width-1:0] rd_data_b1,

    output logic rd_en_b2,
    output logic [acc_addr_width-1:0] rd_line_b2,
    input logic [data_width-1:0] rd_data_b2
);

    scan_addr_u addr_reg;
    scan_addr_u addr_next;
    logic [len_width-1:0] len_reg;
    logic [len_width-1:0] len_next;

    logic cmd_ready_reg;
    logic cmd_ready_next;
    logic rd_en_reg;
    logic rd_en_next;
    logic accept;
    logic scan_end;

    logic status_match_reg;
    logic status_match_next;
    logic status_done_reg;
    logic status_done_next;

    // read return stage: the address that belongs to the line now on rd_data.
    logic ctrl_en_reg;
    scan_addr_u ctrl_addr_reg;
    logic [data_width-1:0] ret_line;
    logic [7:0] ret_byte;

    logic start_d1_reg;
    logic start_d2_reg;
    logic [2:0] end_reg;

    logic [7:0] re_byte_reg;
    logic re_valid_reg;
    logic re_clear_reg;
    logic match;

    assign cmd_ready = cmd_ready_reg;
    assign status_match = status_match_reg;
    assign status_done = status_done_reg;

    assign rd_en_b1 = rd_en_reg && !addr_reg.fields.bank;
    assign rd_line_b1 = addr_reg.fields.line;
    assign rd_en_b2 = rd_en_reg && addr_reg.fields.bank;
    assign rd_line_b2 = addr_reg.fields.line;

    assign ret_line = ctrl_addr_reg.fields.bank ? rd_data_b2 : rd_data_b1;
    assign ret_byte = ret_line[ctrl_addr_reg.fields.byte_sel*8 +: 8];

    regex_ab_c_match re_inst (
        .clk(clk),
        .rst(rst),
        .re_byte(re_byte_reg),
        .re_valid(re_valid_reg),
        .re_clear(re_clear_reg),
        .match(match)
    );

    assign accept = !cmd_stop && cmd_ready_reg && cmd_valid;

    always_comb begin
        addr_next = addr_reg;
        len_next = len_reg;
        cmd_ready_next = cmd_ready_reg;
        rd_en_next = 1'b0;

        if (cmd_stop) begin
            len_next = '0;
            cmd_ready_next = 1'b1;
        end else if (accept) begin
            addr_next.flat = cmd_addr;
            len_next = cmd_len;
            rd_en_next = 1'b1;
            cmd_ready_next = 1'b0;
        end else if (len_reg > 1) begin
            addr_next.flat = addr_reg.flat + 1'b1;
            len_next = len_reg - 1'b1;
            rd_en_next = 1'b1;
        end else begin
            cmd_ready_next = 1'b1;
        end
    end

    // the last read of a scan that ran to its end, not one cut by cmd_stop.
    assign scan_end = rd_en_reg && !rd_en_next && !cmd_stop;

    always_comb begin
        status_match_next = status_match_reg | match;
        status_done_next = status_done_reg | end_reg[2];

        if (start_d2_reg) begin
            status_match_next = 1'b0;
            status_done_next = 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            len_reg <= '0;
            cmd_ready_reg <= 1'b0;
            rd_en_reg <= 1'b0;
            ctrl_en_reg <= 1'b0;
            start_d1_reg <= 1'b0;
            start_d2_reg <= 1'b0;
            end_reg <= '0;
            re_valid_reg <= 1'b0;
            re_clear_reg <= 1'b0;
            status_match_reg <= 1'b0;
            status_done_reg <= 1'b0;
        end else begin
            len_reg <= len_next;
            cmd_ready_reg <= cmd_ready_next;
            rd_en_reg <= rd_en_next;
            ctrl_en_reg <= rd_en_reg && !cmd_stop;

            start_d1_reg <= accept;
            start_d2_reg <= start_d1_reg;

            // a natural end walks all three stages, an abort joins at the
            // second so that done rises two edges after cmd_stop.
            end_reg[0] <= scan_end;
            end_reg[1] <= end_reg[0] | cmd_stop;
            end_reg[2] <= end_reg[1];

            re_valid_reg <= ctrl_en_reg && !cmd_stop;
            re_clear_reg <= start_d1_reg | cmd_stop;

            status_match_reg <= status_match_next;
            status_done_reg <= status_done_next;
        end
    end

    always_ff @(posedge clk) begin
        addr_reg <= addr_next;
        ctrl_addr_reg <= addr_reg;
        if (ctrl_en_reg) begin
            re_byte_reg <= ret_byte;
        end
    end

endmodule

`default_nettype wire

// File: regex_scan_top.sv
`default_nettype none

module regex_scan_top
    import regex_scan_pkg::*;
(
    input logic clk,
    input logic rst,

    input logic wr_en,
    input logic [pmem_addr_width-1:0] wr_addr,
    input logic [7:0] wr_data,

    input logic [pmem_addr_width-1:0] cmd_addr,
    input logic [len_width-1:0] cmd_len,
    input logic cmd_valid,
    input logic cmd_stop,
    output logic cmd_ready,

    output logic status_match,
    output logic status_done
);

    scan_addr_u wr_addr_u;
    logic wr_en_b1;
    logic wr_en_b2;
    logic [strb_width-1:0] wr_strb;
    logic [data_width-1:0] wr_line_data;

    logic rd_en_b1;
    logic rd_en_b2;
    logic [acc_addr_width-1:0] rd_line_b1;
    logic [acc_addr_width-1:0] rd_line_b2;
    logic [data_width-1:0] rd_data_b1;
    logic [data_width-1:0] rd_data_b2;

    // a host byte goes to every lane and the strobe picks the one it lands in.
    assign wr_addr_u.flat = wr_addr;
    assign wr_en_b1 = wr_en && !wr_addr_u.fields.bank;
    assign wr_en_b2 = wr_en && wr_addr_u.fields.bank;
    assign wr_strb = strb_width'(1) << wr_addr_u.fields.byte_sel;
    assign wr_line_data = {strb_width{wr_data}};

    scan_bank_mem bank1_inst (
        .clk(clk),
        .wr_en(wr_en_b1),
        .wr_line(wr_addr_u.fields.line),
        .wr_strb(wr_strb),
        .wr_data(wr_line_data),
        .rd_en(rd_en_b1),
        .rd_line(rd_line_b1),
        .rd_data(rd_data_b1)
    );

    scan_bank_mem bank2_inst (
        .clk(clk),
        .wr_en(wr_en_b2),
        .wr_line(wr_addr_u.fields.line),
        .wr_strb(wr_strb),
        .wr_data(wr_line_data),
        .rd_en(rd_en_b2),
        .rd_line(rd_line_b2),
        .rd_data(rd_data_b2)
    );

    regex_scan_ctrl regex_scan_ctrl_inst (
        .clk(clk),
        .rst(rst),
        .cmd_addr(cmd_addr),
        .cmd_len(cmd_len),
        .cmd_valid(cmd_valid),
        .cmd_stop(cmd_stop),
        .cmd_ready(cmd_ready),
        .status_match(status_match),
        .status_done(status_done),
        .rd_en_b1(rd_en_b1),
        .rd_line_b1(rd_line_b1),
        .rd_data_b1(rd_data_b1),
        .rd_en_b2(rd_en_b2),
        .rd_line_b2(rd_line_b2),
        .rd_data_b2(rd_data_b2)
    );

endmodule

`default_nettype wire

// File: regex_scan_assert.sv
`default_nettype none

module regex_scan_assert (
    input logic clk,
    input logic rst,
    input logic cmd_valid,
    input logic cmd_stop,
    input logic cmd_ready,
    input logic status_done,
    input logic rd_en_b1,
    input logic rd_en_b2
);
    timeunit 1ns;
    timeprecision 100ps;

    int fail_count = 0;
    logic accept;

    assign accept = cmd_valid && cmd_ready && !cmd_stop;

    // bank reads belong to a running scan, so the command port is busy.
    read_while_busy: assert property (@(posedge clk) disable iff (rst)
        (rd_en_b1 || rd_en_b2) |-> !cmd_ready)
    else begin
        fail_count++;
        $error("a bank read was issued while cmd_ready was high");
    end

    // status is cleared at the second edge, which the third sample sees.
    done_cleared: assert property (@(posedge clk) disable iff (rst)
        accept |-> ##3 !status_done)
    else begin
        fail_count++;
        $error("status_done was not cleared after an accepted command");
    end

    ready_dropped: assert property (@(posedge clk) disable iff (rst)
        accept |=> !cmd_ready)
    else begin
        fail_count++;
        $error("cmd_ready stayed high after an accepted command");
    end

endmodule

bind regex_scan_ctrl regex_scan_assert regex_scan_assert_inst (
    .clk(clk),
    .rst(rst),
    .cmd_valid(cmd_valid),
    .cmd_stop(cmd_stop),
    .cmd_ready(cmd_ready),
    .status_done(status_done),
    .rd_en_b1(rd_en_b1),
    .rd_en_b2(rd_en_b2)
);

`default_nettype wire

// File: regex_scan_tb.sv
`default_nettype none

module regex_scan_tb
    import regex_scan_pkg::*;
();
    timeunit 1ns;
    timeprecision 100ps;

    localparam int clk_period_ns = 4;
    localparam int n_cmds = 200;
    localparam int cycles_per_cmd = 80;
    localparam int n_random_scans = 120;
    localparam int n_boundary_scans = 24;
    localparam int n_abort_scans = 6;
    localparam int mem_bytes = 512;

    logic clk = 1'b0;
    logic rst;
    logic wr_en;
    logic [pmem_addr_width-1:0] wr_addr;
    logic [7:0] wr_data;
    logic [pmem_addr_width-1:0] cmd_addr;
    logic [len_width-1:0] cmd_len;
    logic cmd_valid;
    logic cmd_stop;
    logic cmd_ready;
    logic status_match;
    logic status_done;

    // mirror of every byte that the host has written.
    logic [7:0] mirror [mem_bytes];
    integer seed = 32'hd652;

    always #(clk_period_ns / 2) clk = ~clk;

    regex_scan_top regex_scan_top_inst (
        .clk(clk),
        .rst(rst),
        .wr_en(wr_en),
        .wr_addr(wr_addr),
        .wr_data(wr_data),
        .cmd_addr(cmd_addr),
        .cmd_len(cmd_len),
        .cmd_valid(cmd_valid),
        .cmd_stop(cmd_stop),
        .cmd_ready(cmd_ready),
        .status_match(status_match),
        .status_done(status_done)
    );

    task automatic fail_run(input string msg);
        $display("%s", msg);
        $display("Simulation finished: FAIL");
        $fatal(1, "stopping at the first error");
    endtask

    task automatic next_cycle();
        @(posedge clk);
        #0.5;
        if (regex_scan_top_inst.regex_scan_ctrl_inst.regex_scan_assert_inst.fail_count != 0) begin
            fail_run("a bound assertion on the scan controller failed");
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic expected);
        if (got !== expected) begin
            fail_run($sformatf("MISMATCH %s: got 0x%0h expected 0x%0h", name, got, expected));
        end
    endtask

    task automatic check_byte_count(input int got, input logic [len_width-1:0] len);
        int expected;
        expected = int'(len) + 3;
        if (got != expected) begin
            fail_run($sformatf("MISMATCH status_done latency: got 0x%0h expected 0x%0h",
                got, expected));
        end
    endtask

    function automatic int rand_below(input int n);
        return int'($unsigned($random(seed)) % n);
    endfunction

    // 'x' is drawn more often so that only some windows hold a match.
    function automatic logic [7:0] random_letter();
        int pick;
        pick = rand_below(8);
        case (pick)
            0: return "a";
            1: return "b";
            2: return "c";
            default: return "x";
        endcase
    endfunction

    // walks the bytes with the "ab*c" rule, starting from idle.
    function automatic logic expected_match(input int start, input int len);
        int state;
        logic found;
        logic [7:0] ch;
        state = 0;
        found = 1'b0;
        for (int k = 0; k < len; k++) begin
            ch = mirror[start + k];
            if (ch == "a") state = 1;
            else if (ch == "b" && state != 0) state = 2;
            else if (ch == "c" && state != 0) begin
                found = 1'b1;
                state = 0;
            end else state = 0;
        end
        return found;
    endfunction

    task automatic write_byte(input int addr, input logic [7:0] data);
        wr_en = 1'b1;
        wr_addr = pmem_addr_width'(addr);
        wr_data = data;
        mirror[addr] = data;
        next_cycle();
        wr_en = 1'b0;
    endtask

    // writes 'a', nb times 'b', then 'c'.
    task automatic plant(input int addr, input int nb);
        write_byte(addr, "a");
        for (int i = 1; i <= nb; i++) write_byte(addr + i, "b");
        write_byte(addr + nb + 1, "c");
    endtask

    task automatic wait_ready(input int limit);
        int n;
        n = 0;
        while (!cmd_ready) begin
            if (n == limit) fail_run("cmd_ready did not rise in time");
            next_cycle();
            n++;
        end
    endtask

    task automatic issue_cmd(input int start, input int len);
        wait_ready(cycles_per_cmd);
        cmd_addr = pmem_addr_width'(start);
        cmd_len = len_width'(len);
        cmd_valid = 1'b1;
        next_cycle();
        cmd_valid = 1'b0;
    endtask

    task automatic run_scan(input int start, input int len);
        int cycles;
        issue_cmd(start, len);
        cycles = 0;
        // done of the previous scan stays up until the second edge.
        do begin
            next_cycle();
            cycles++;
            if (cycles > cycles_per_cmd) fail_run("status_done never rose after a scan");
        end while (!(cycles > 2 && status_done));
        check_byte_count(cycles, len_width'(len));
        check_flag("status_match", status_match, expected_match(start, len));
        check_flag("cmd_ready", cmd_ready, 1'b1);
    endtask

    task automatic run_abort(input int start, input int len, input int stop_after);
        issue_cmd(start, len);
        repeat (stop_after) next_cycle();
        cmd_stop = 1'b1;
        next_cycle();
        cmd_stop = 1'b0;
        check_flag("cmd_ready", cmd_ready, 1'b1);
        repeat (2) next_cycle();
        check_flag("status_done", status_done, 1'b1);
        check_flag("cmd_ready", cmd_ready, 1'b1);
    endtask

    initial begin
        #(n_cmds * cycles_per_cmd * clk_period_ns);
        fail_run("timeout: the test sequence did not finish in time");
    end

    initial begin
        int start;
        int len;
        int line;
        rst = 1'b1;
        wr_en = 1'b0;
        wr_addr = '0;
        wr_data = '0;
        cmd_addr = '0;
        cmd_len = '0;
        cmd_valid = 1'b0;
        cmd_stop = 1'b0;
        repeat (3) next_cycle();
        rst = 1'b0;
        check_flag("status_done", status_done, 1'b0);
        check_flag("status_match", status_match, 1'b0);
        wait_ready(2);

        for (int a = 0; a < mem_bytes; a++) write_byte(a, random_letter());

        for (int i = 0; i < n_random_scans; i++) begin
            repeat (4) write_byte(rand_below(mem_bytes), random_letter());
            if (rand_below(2) == 1) plant(rand_below(mem_bytes - 8), 1 + rand_below(4));
            len = 1 + rand_below(60);
            start = rand_below(mem_bytes);
            if (start + len > mem_bytes) start = mem_bytes - len;
            run_scan(start, len);
        end

        // odd start bytes, with patterns that run over a line and so a bank change.
        // the last line used leaves room for the longest scan below the top byte.
        for (int i = 0; i < n_boundary_scans; i++) begin
            line = rand_below(124);
            start = line * 4 + ((i % 2 == 1) ? 3 : 1);
            len = 1 + rand_below(3);
            plant(start + ((i % 2 == 1) ? 0 : 1), len);
            if (i % 3 == 2) write_byte(start + len + 1, "x");
            run_scan(start, 8 + rand_below(8));
        end

        for (int i = 0; i < n_abort_scans; i++) begin
            len = 20 + rand_below(40);
            start = rand_below(mem_bytes - len);
            plant(start + rand_below(10), 1 + rand_below(3));
            run_abort(start, len, 3 + rand_below(10));
            run_scan(start, len);
        end

        $display("Simulation finished: PASS");
        $finish;
    end

endmodule

`default_nettype wire

// File: compile.f
regex_scan_pkg.sv
scan_bank_mem.sv
regex_ab_c_match.sv
regex_scan_ctrl.sv
regex_scan_top.sv
regex_scan_assert.sv
regex_scan_tb.sv
